/* design/glyph_defines.svh */
`ifndef GLYPH_DEFINES_SVH
`define GLYPH_DEFINES_SVH

// Column FIFO entries, power of two
`define COL_FIFO_DEPTH 16

// Codes from here up are 8-wide digits
`define GLYPH_NARROW_FIRST 6

// Columns sent per glyph
`define GLYPH_WIDE_COLS 16
`define GLYPH_NARROW_COLS 8

`endif

/* design/glyph_pkg.sv */
package glyph_pkg;

    // Character code from the host
    typedef logic [3:0] glyph_code_t;

    // One 8-pixel page byte of a column
    // Bit 0 is the top pixel row of the page
    typedef logic [7:0] col_byte_t;

    // Panel column position, wraps at 128
    typedef logic [6:0] col_addr_t;

endpackage

/* design/column_if.sv */
`timescale 1ns/1ns

interface column_if import glyph_pkg::*; ();

    // Transfer strobe, one cycle per column
    logic      xfer;
    // Full on the push side, empty on the pop side
    logic      blocked;
    // Column bytes, top page and bottom page
    col_byte_t top;
    col_byte_t btm;

    // Producer end of the push link
    modport push_src (
        output xfer, top, btm,
        input  blocked
    );

    // FIFO write port
    modport push_dst (
        input  xfer, top, btm,
        output blocked
    );

    // FIFO read port, shows oldest entry
    modport pop_src (
        output top, btm, blocked,
        input  xfer
    );

    // Consumer end of the pop link
    modport pop_dst (
        input  top, btm, blocked,
        output xfer
    );

endinterface

/* design/glyph_rom.sv */
`timescale 1ns/1ns

module glyph_rom import glyph_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  glyph_code_t  code,
    output logic [127:0] row_top,
    output logic [127:0] row_btm
);

    // Registered lookup, rows valid one clock after code
    // Leftmost column sits in the most significant byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_top <= '0;
            row_btm <= '0;
        end else begin
            case (code)
                //////////////////////////////////////////////////
                // Wide 16x16 ideographs
                //////////////////////////////////////////////////
                4'd0: begin
                    row_top <= 128'h00_00_F8_49_4A_4C_48_F8_48_4C_4A_49_F8_00_00_00;
                    row_btm <= 128'h10_10_13_12_12_12_12_FF_12_12_12_12_13_10_10_00;
                end
                4'd1: begin
                    row_top <= 128'h40_40_42_44_58_C0_40_7F_40_C0_50_48_46_40_40_00;
                    row_btm <= 128'h80_80_40_20_18_07_00_00_00_3F_40_40_40_40_78_00;
                end
                4'd2: begin
                    row_top <= 128'h80_82_82_82_82_82_82_E2_A2_92_8A_86_82_80_80_00;
                    row_btm <= 128'h00_00_00_00_00_40_80_7F_00_00_00_00_00_00_00_00;
                end
                4'd3: begin
                    row_top <= 128'h40_40_42_CC_00_40_40_40_40_FF_40_40_40_40_40_00;
                    row_btm <= 128'h00_00_00_7F_20_10_00_00_00_FF_00_00_00_00_00_00;
                end
                4'd4: begin
                    row_top <= 128'h90_52_34_10_FF_10_34_52_80_70_8F_08_08_F8_08_00;
                    row_btm <= 128'h82_9A_56_63_22_52_8E_00_80_40_33_0C_33_40_80_00;
                end
                4'd5: begin
                    row_top <= 128'h80_80_9E_92_92_92_9E_E0_80_9E_B2_D2_92_9E_80_00;
                    row_btm <= 128'h08_08_F4_94_92_92_F1_00_01_F2_92_94_94_F8_08_00;
                end
                //////////////////////////////////////////////////
                // Narrow 8x16 digits 0 to 9
                // Right half is zero padding, never sent
                //////////////////////////////////////////////////
                4'd6: begin
                    row_top <= 128'h00_E0_10_08_08_10_E0_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_0F_10_20_20_10_0F_00_00_00_00_00_00_00_00_00;
                end
                4'd7: begin
                    row_top <= 128'h00_00_10_10_F8_00_00_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_00_20_20_3F_20_20_00_00_00_00_00_00_00_00_00;
                end
                4'd8: begin
                    row_top <= 128'h00_70_08_08_08_08_F0_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_30_28_24_22_21_30_00_00_00_00_00_00_00_00_00;
                end
                4'd9: begin
                    row_top <= 128'h00_30_08_08_08_88_70_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_18_20_21_21_22_1C_00_00_00_00_00_00_00_00_00;
                end
                4'd10: begin
                    row_top <= 128'h00_00_80_40_30_F8_00_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_06_05_24_24_3F_24_24_00_00_00_00_00_00_00_00;
                end
                4'd11: begin
                    row_top <= 128'h00_F8_88_88_88_08_08_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_19_20_20_20_11_0E_00_00_00_00_00_00_00_00_00;
                end
                4'd12: begin
                    row_top <= 128'h00_E0_10_88_88_90_00_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_0F_11_20_20_20_1F_00_00_00_00_00_00_00_00_00;
                end
                4'd13: begin
                    row_top <= 128'h00_18_08_08_88_68_18_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_00_00_3E_01_00_00_00_00_00_00_00_00_00_00_00;
                end
                4'd14: begin
                    row_top <= 128'h00_70_88_08_08_88_70_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_1C_22_21_21_22_1C_00_00_00_00_00_00_00_00_00;
                end
                // Digit 9
                default: begin
                    row_top <= 128'h00_F0_08_08_08_10_E0_00_00_00_00_00_00_00_00_00;
                    row_btm <= 128'h00_01_12_22_22_11_0F_00_00_00_00_00_00_00_00_00;
                end
            endcase
        end
    end

endmodule

/* design/glyph_fetch.sv */
`timescale 1ns/1ns
`include "glyph_defines.svh"

module glyph_fetch import glyph_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  glyph_code_t char_code,
    input  logic        char_strobe,
    output logic        busy,
    column_if.push_src  push
);

    // Index of the final column per width
    localparam logic [3:0] WIDE_LAST   = 4'(`GLYPH_WIDE_COLS - 1);
    localparam logic [3:0] NARROW_LAST = 4'(`GLYPH_NARROW_COLS - 1);
    localparam glyph_code_t NARROW_FIRST = glyph_code_t'(`GLYPH_NARROW_FIRST);

    typedef enum logic [1:0] {F_IDLE, F_WAIT, F_PUSH} fetch_state_t;

    fetch_state_t state;
    glyph_code_t  code_q;
    logic         wide_q;
    logic [3:0]   col_idx;
    logic [127:0] row_top;
    logic [127:0] row_btm;
    logic [6:0]   byte_base;
    logic         last_col;

    glyph_rom u_rom (
        .clk     (clk),
        .rst_n   (rst_n),
        .code    (code_q),
        .row_top (row_top),
        .row_btm (row_btm)
    );

    assign busy     = (state != F_IDLE);
    assign last_col = (col_idx == (wide_q ? WIDE_LAST : NARROW_LAST));

    // Column k is byte k from the MSB end, i.e. bit offset 8*(15-k)
    assign byte_base = {~col_idx, 3'b000};

    // Push whenever the FIFO has room
    assign push.xfer = (state == F_PUSH) && !push.blocked;
    assign push.top  = row_top[byte_base +: 8];
    assign push.btm  = row_btm[byte_base +: 8];

    //////////////////////////////////////////////////
    // Fetch FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= F_IDLE;
            code_q  <= '0;
            wide_q  <= 1'b0;
            col_idx <= '0;
        end else begin
            case (state)
                // Strobes only count here
                F_IDLE: if (char_strobe) begin
                    code_q  <= char_code;
                    wide_q  <= (char_code < NARROW_FIRST);
                    col_idx <= '0;
                    state   <= F_WAIT;
                end
                // ROM latency
                F_WAIT: state <= F_PUSH;
                F_PUSH: if (push.xfer) begin
                    col_idx <= col_idx + 4'd1;
                    if (last_col)
                        state <= F_IDLE;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

endmodule

/* design/column_fifo.sv */
`timescale 1ns/1ns
`include "glyph_defines.svh"

module column_fifo import glyph_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    column_if.push_dst push,
    column_if.pop_src  pop
);

    localparam int DEPTH = `COL_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = DEPTH[AW:0];

    // Byte pair storage
    col_byte_t     mem_top [DEPTH];
    col_byte_t     mem_btm [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          empty;
    logic          do_push;
    logic          do_pop;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);

    // Levels back to each side
    assign push.blocked = full;
    assign pop.blocked  = empty;

    // Head of queue always visible
    assign pop.top = mem_top[rd_ptr];
    assign pop.btm = mem_btm[rd_ptr];

    assign do_push = push.xfer && !full;
    assign do_pop  = pop.xfer && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_top[wr_ptr] <= push.top;
            mem_btm[wr_ptr] <= push.btm;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/column_serializer.sv */
`timescale 1ns/1ns

module column_serializer import glyph_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    column_if.pop_dst pop,
    output logic      ser_clk,
    output logic      ser_data,
    output logic      ser_latch,
    output col_addr_t col_addr
);

    typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_LATCH} ser_state_t;

    ser_state_t  state;
    logic [15:0] shreg;
    logic [3:0]  bit_cnt;
    // Low half then high half of each bit
    logic        phase;

    // Pop as soon as idle with data waiting
    assign pop.xfer = (state == S_IDLE) && !pop.blocked;

    // Line outputs follow the state
    assign ser_clk   = (state == S_SHIFT) && phase;
    assign ser_data  = (state == S_SHIFT) && shreg[15];
    assign ser_latch = (state == S_LATCH);

    // Word is {top, btm}, MSB goes out first
    always_ff @(posedge clk) begin
        if (pop.xfer)
            shreg <= {pop.top, pop.btm};
        else if ((state == S_SHIFT) && phase)
            shreg <= {shreg[14:0], 1'b0};
    end

    //////////////////////////////////////////////////
    // Shift FSM, 32 shift cycles then one latch
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            phase    <= 1'b0;
            col_addr <= '0;
        end else begin
            case (state)
                S_IDLE: if (pop.xfer) begin
                    bit_cnt <= '0;
                    phase   <= 1'b0;
                    state   <= S_SHIFT;
                end
                S_SHIFT: begin
                    phase <= ~phase;
                    // Bit done after its high half
                    if (phase) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd15)
                            state <= S_LATCH;
                    end
                end
                // Address moves on after the latch, wraps at 128
                S_LATCH: begin
                    col_addr <= col_addr + 1'b1;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* design/glyph_display.sv */
`timescale 1ns/1ns

module glyph_display (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] char_code,
    input  logic       char_strobe,
    output logic       busy,
    output logic       ser_clk,
    output logic       ser_data,
    output logic       ser_latch,
    output logic [6:0] col_addr
);

    // Fetcher to FIFO
    column_if push_link ();
    // FIFO to serializer
    column_if pop_link ();

    // Glyph lookup and column push
    glyph_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .char_code   (char_code),
        .char_strobe (char_strobe),
        .busy        (busy),
        .push        (push_link.push_src)
    );

    // Back-pressure buffer
    column_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push_link.push_dst),
        .pop   (pop_link.pop_src)
    );

    // Two-wire panel output
    column_serializer u_ser (
        .clk       (clk),
        .rst_n     (rst_n),
        .pop       (pop_link.pop_dst),
        .ser_clk   (ser_clk),
        .ser_data  (ser_data),
        .ser_latch (ser_latch),
        .col_addr  (col_addr)
    );

endmodule

/* testbench/glyph_display_chk.sv */
`timescale 1ns/1ns

module glyph_display_chk (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic ser_clk,
    input logic ser_data,
    input logic ser_latch
);

    // Count of failed assertions, polled by the testbench top
    int fail_count = 0;

    // Latch is a one-cycle pulse
    latch_single: assert property (@(posedge clk) disable iff (!rst_n)
        ser_latch |=> !ser_latch)
        else begin
            fail_count++;
            $error("ser_latch high for two cycles in a row");
        end

    // Panel clock parked low during latch
    latch_clk_low: assert property (@(posedge clk) disable iff (!rst_n)
        ser_latch |-> !ser_clk)
        else begin
            fail_count++;
            $error("ser_clk high while ser_latch is high");
        end

    // Data set up in the low half, held through the high half
    data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ser_clk |-> $stable(ser_data))
        else begin
            fail_count++;
            $error("ser_data changed while ser_clk is high");
        end

    // Nothing accepted yet in the first cycle out of reset
    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !busy)
        else begin
            fail_count++;
            $error("busy high in the first cycle after reset");
        end

endmodule

bind glyph_display glyph_display_chk u_chk (.*);

/* testbench/glyph_display_tb.sv */
`timescale 1ns/1ns
`include "glyph_defines.svh"

module glyph_display_tb;

    // Code plus sixteen words per pattern line
    localparam int LINE_WORDS  = 17;
    localparam int TOTAL_COLS  = 6 * `GLYPH_WIDE_COLS + 10 * `GLYPH_NARROW_COLS;
    localparam int IDLE_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 4000;

    logic       clk;
    logic       rst_n;
    logic [3:0] char_code;
    logic       char_strobe;
    logic       busy;
    logic       ser_clk;
    logic       ser_data;
    logic       ser_latch;
    logic [6:0] col_addr;

    logic [15:0] pat_mem [0:16*LINE_WORDS-1];
    // Columns still owed on the wire, oldest first
    logic [15:0] exp_q [$];
    logic [31:0] lfsr;
    logic [15:0] rx_word;
    logic [4:0]  rx_bits;
    logic        ser_clk_d;
    logic [6:0]  model_addr;

    glyph_display dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .char_code   (char_code),
        .char_strobe (char_strobe),
        .busy        (busy),
        .ser_clk     (ser_clk),
        .ser_data    (ser_data),
        .ser_latch   (ser_latch),
        .col_addr    (col_addr)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            n++;
            if (n > IDLE_LIMIT) begin
                $display("Timed out waiting for busy to fall");
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // One glyph request, optional ignored strobe
    //////////////////////////////////////////////////
    task automatic send_glyph(input logic [3:0] code, input logic decoy);
        logic [1:0] gap;
        int         n;
        wait_idle();
        take_bit(gap[0]);
        take_bit(gap[1]);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        char_code   <= code;
        char_strobe <= 1'b1;
        check_value("pattern code", pat_mem[code*LINE_WORDS], code);
        // Digits send only their left eight columns
        n = (code < `GLYPH_NARROW_FIRST) ? `GLYPH_WIDE_COLS : `GLYPH_NARROW_COLS;
        for (int k = 0; k < n; k++)
            exp_q.push_back(pat_mem[code*LINE_WORDS + 1 + k]);
        @(posedge clk);
        // Sampled next edge with busy already high
        char_code   <= code ^ 4'hA;
        char_strobe <= decoy;
        @(negedge clk);
        check_value("busy", busy, 1);
        if (decoy) begin
            @(posedge clk);
            char_strobe <= 1'b0;
        end
    endtask

    //////////////////////////////////////////////////
    // Wire monitor, sampled mid-cycle
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            // One bit per rising panel clock
            if (ser_clk && !ser_clk_d) begin
                rx_word <= {rx_word[14:0], ser_data};
                rx_bits <= rx_bits + 5'd1;
            end
            if (ser_latch) begin
                if (exp_q.size() == 0) begin
                    $display("A column was latched when none was expected");
                    abort_run();
                end
                check_value("bit count", rx_bits, 16);
                check_value("ser_data word", rx_word, exp_q[0]);
                check_value("col_addr", col_addr, model_addr);
                void'(exp_q.pop_front());
                model_addr <= model_addr + 7'd1;
                rx_bits    <= '0;
            end
        end
        ser_clk_d <= ser_clk;
    end

    // Watch the bound checker
    always @(negedge clk) begin
        if (dut0.u_chk.fail_count != 0) begin
            $display("A bound assertion on the panel outputs failed");
            abort_run();
        end
    end

    initial begin
        int n;
        clk         = 1'b0;
        rst_n       = 1'b0;
        char_code   = '0;
        char_strobe = 1'b0;
        lfsr        = 32'hb99e_5002;
        rx_word     = '0;
        rx_bits     = '0;
        ser_clk_d   = 1'b0;
        model_addr  = '0;
        $readmemh("testbench/glyph_patterns.txt", pat_mem);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Levels straight out of reset
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("ser_clk", ser_clk, 0);
        check_value("ser_data", ser_data, 0);
        check_value("ser_latch", ser_latch, 0);
        check_value("col_addr", col_addr, 0);

        // All sixteen codes back to back, 176 columns wrap the address
        for (int c = 0; c < 16; c++)
            send_glyph(4'(c), c[0]);

        n = 0;
        while (exp_q.size() != 0) begin
            n++;
            if (n > DRAIN_LIMIT) begin
                $display("Timed out waiting for the last columns on the wire");
                abort_run();
            end
            @(negedge clk);
        end
        // Room for a stray extra column to show up
        repeat (80) @(posedge clk);
        @(negedge clk);

        // Address after the final latch, wrapped at 128
        check_value("col_addr", col_addr, TOTAL_COLS % 128);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* glyph_display.f */
+incdir+design
design/glyph_pkg.sv
design/column_if.sv
design/glyph_rom.sv
design/glyph_fetch.sv
design/column_fifo.sv
design/column_serializer.sv
design/glyph_display.sv
testbench/glyph_display_chk.sv
testbench/glyph_display_tb.sv

/* testbench/glyph_patterns.txt */
// code, then sixteen column words {top byte, bottom byte}, leftmost column first
// narrow digits (codes 6 to f) pad words 8 to 15 with zero
0000 0010 0010 F813 4912 4A12 4C12 4812 F8FF 4812 4C12 4A12 4912 F813 0010 0010 0000
0001 4080 4080 4240 4420 5818 C007 4000 7F00 4000 C03F 5040 4840 4640 4040 4078 0000
0002 8000 8200 8200 8200 8200 8240 8280 E27F A200 9200 8A00 8600 8200 8000 8000 0000
0003 4000 4000 4200 CC7F 0020 4010 4000 4000 4000 FFFF 4000 4000 4000 4000 4000 0000
0004 9082 529A 3456 1063 FF22 1052 348E 5200 8080 7040 8F33 080C 0833 F840 0880 0000
0005 8008 8008 9EF4 9294 9292 9292 9EF1 E000 8001 9EF2 B292 D294 9294 9EF8 8008 0000
0006 0000 E00F 1010 0820 0820 1010 E00F 0000 0000 0000 0000 0000 0000 0000 0000 0000
0007 0000 0000 1020 1020 F83F 0020 0020 0000 0000 0000 0000 0000 0000 0000 0000 0000
0008 0000 7030 0828 0824 0822 0821 F030 0000 0000 0000 0000 0000 0000 0000 0000 0000
0009 0000 3018 0820 0821 0821 8822 701C 0000 0000 0000 0000 0000 0000 0000 0000 0000
000A 0000 0006 8005 4024 3024 F83F 0024 0024 0000 0000 0000 0000 0000 0000 0000 0000
000B 0000 F819 8820 8820 8820 0811 080E 0000 0000 0000 0000 0000 0000 0000 0000 0000
000C 0000 E00F 1011 8820 8820 9020 001F 0000 0000 0000 0000 0000 0000 0000 0000 0000
000D 0000 1800 0800 083E 8801 6800 1800 0000 0000 0000 0000 0000 0000 0000 0000 0000
000E 0000 701C 8822 0821 0821 8822 701C 0000 0000 0000 0000 0000 0000 0000 0000 0000
000F 0000 F001 0812 0822 0822 1011 E00F 0000 0000 0000 0000 0000 0000 0000 0000 0000
